// ==== source/control_cfg.svh ====
`ifndef CONTROL_CFG_SVH
`define CONTROL_CFG_SVH

// primary opcode field, bits 31:26 of the instruction
`define OPC_RFMT 6'b000000
`define OPC_J 6'b000010
`define OPC_JAL 6'b000011
`define OPC_BEQ 6'b000100
`define OPC_BNE 6'b000101
`define OPC_ADDI 6'b001000
`define OPC_ADDIU 6'b001001
`define OPC_SLTI 6'b001010
`define OPC_SLTIU 6'b001011
`define OPC_ANDI 6'b001100
`define OPC_ORI 6'b001101
`define OPC_XORI 6'b001110
`define OPC_LUI 6'b001111
`define OPC_LW 6'b100011
`define OPC_SW 6'b101011
`define OPC_COP0 6'b010000

// funct field of R-format words
`define FUN_ADD 6'b100000
`define FUN_ADDU 6'b100001
`define FUN_SUB 6'b100010
`define FUN_SUBU 6'b100011
`define FUN_AND 6'b100100
`define FUN_OR 6'b100101
`define FUN_XOR 6'b100110
`define FUN_NOR 6'b100111
`define FUN_SLT 6'b101010
`define FUN_SLTU 6'b101011
`define FUN_SLL 6'b000000
`define FUN_SRL 6'b000010
`define FUN_SRA 6'b000011
`define FUN_JR 6'b001000
`define FUN_SYSCALL 6'b001100
`define FUN_MULT 6'b011000
`define FUN_MULTU 6'b011001
`define FUN_DIV 6'b011010
`define FUN_DIVU 6'b011011
// eret shares its funct value with mult, only the cop0 opcode tells them apart
`define FUN_ERET 6'b011000

// rs field of cop0 words
`define FMT_MTC 5'b00100
`define FMT_MFC 5'b00000
`define FMT_ERET 5'b10000

// cause register exception codes
`define EXC_INT 5'd0
`define EXC_SYS 5'd8
`define EXC_INSTR 5'd10
`define EXC_ALU 5'd12

`endif

// ==== source/controlPkg.sv ====
`default_nettype none

package controlPkg;

	// execution states, one cycle each
	typedef enum logic [5:0]
	{
		FETCH,
		DECODE,
		RFMT,
		RFMT2,
		SHIFT,
		IFMTL,
		IFMTA,
		IFMT2,
		LWSW,
		LW,
		LW2,
		SW,
		BEQ,
		BNE,
		JUMP,
		JAL,
		JR,
		COP0MTC0,
		COP0MFC0,
		COP0ERET,
		COP0EXC
	} ctrlStateT;

	// datapath control word, pcWrite is the msb
	typedef struct packed
	{
		logic pcWrite;
		logic pcWriteBne;
		logic pcWriteBeq;
		logic iorD;
		logic memRead;
		logic memWrite;
		logic irWrite;
		logic memtoReg;
		logic regWrite;
		logic regDst;
		// 0 alu result, 1 alu out reg, 2 jump target, 3 register, 4 handler, 5 epc
		logic [2:0] pcSource;
		logic [1:0] aluOp;
		logic [2:0] aluSrcB;
		logic [1:0] aluSrcA;
		// write-back source select
		logic [2:0] store;
	} ctrlWordT;

	// what the decoder makes of opcode, funct and fmt
	typedef enum logic [4:0]
	{
		RTYPE,
		SHIFTOP,
		MULTDIV,
		JROP,
		SYSCALL,
		ILOGIC,
		IARITH,
		LOAD,
		STORE,
		BRANCHEQ,
		BRANCHNE,
		JUMPOP,
		JALOP,
		MTC0OP,
		MFC0OP,
		ERETOP,
		ILLEGAL
	} instrKindT;

	typedef struct packed
	{
		instrKindT kind;
		// add, sub, addi
		logic mayOverflow;
		// the next word sits in a branch delay slot
		logic delaySlot;
	} instrClassT;

	// strobes and status toward coprocessor 0
	typedef struct packed
	{
		logic pcOriginalWrite;
		logic regWrite;
		logic eret;
		logic excOccurred;
		logic branchDelay;
		logic interrupted;
		logic [4:0] excCode;
	} cop0CtrlT;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_cfg.svh"

module instrDecoder
	import controlPkg::*;
(
	input wire logic [5:0] iOp,
	input wire logic [5:0] iFunct,
	input wire logic [4:0] iFmt,
	output instrClassT oClass
);

	always_comb
	begin
		// anything not matched below is illegal
		oClass.kind = ILLEGAL;
		oClass.mayOverflow = 1'b0;
		oClass.delaySlot = 1'b0;
		case (iOp)
			`OPC_RFMT:
				case (iFunct)
					`FUN_ADD, `FUN_SUB:
					begin
						oClass.kind = RTYPE;
						oClass.mayOverflow = 1'b1;
					end
					// unsigned and logical ops never trap
					`FUN_ADDU, `FUN_SUBU, `FUN_AND, `FUN_OR, `FUN_XOR, `FUN_NOR,
					`FUN_SLT, `FUN_SLTU:
						oClass.kind = RTYPE;
					`FUN_SLL, `FUN_SRL, `FUN_SRA:
						oClass.kind = SHIFTOP;
					`FUN_MULT, `FUN_MULTU, `FUN_DIV, `FUN_DIVU:
						oClass.kind = MULTDIV;
					`FUN_JR:
					begin
						oClass.kind = JROP;
						oClass.delaySlot = 1'b1;
					end
					`FUN_SYSCALL:
						oClass.kind = SYSCALL;
					default:
						oClass.kind = ILLEGAL;
				endcase
			`OPC_J:
			begin
				oClass.kind = JUMPOP;
				oClass.delaySlot = 1'b1;
			end
			`OPC_JAL:
			begin
				oClass.kind = JALOP;
				oClass.delaySlot = 1'b1;
			end
			`OPC_BEQ:
			begin
				oClass.kind = BRANCHEQ;
				oClass.delaySlot = 1'b1;
			end
			`OPC_BNE:
			begin
				oClass.kind = BRANCHNE;
				oClass.delaySlot = 1'b1;
			end
			`OPC_ADDI:
			begin
				oClass.kind = IARITH;
				oClass.mayOverflow = 1'b1;
			end
			`OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU, `OPC_LUI:
				oClass.kind = IARITH;
			// zero-extended immediates
			`OPC_ANDI, `OPC_ORI, `OPC_XORI:
				oClass.kind = ILOGIC;
			`OPC_LW:
				oClass.kind = LOAD;
			`OPC_SW:
				oClass.kind = STORE;
			`OPC_COP0:
				case (iFmt)
					`FMT_MTC:
						oClass.kind = MTC0OP;
					`FMT_MFC:
						oClass.kind = MFC0OP;
					// eret also needs its own funct
					`FMT_ERET:
						oClass.kind = (iFunct == `FUN_ERET) ? ERETOP : ILLEGAL;
					default:
						oClass.kind = ILLEGAL;
				endcase
			default:
				oClass.kind = ILLEGAL;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/stateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_cfg.svh"

module stateSequencer
	import controlPkg::*;
(
	input wire logic iCLK,
	input wire logic iRST,
	input instrClassT iClass,
	input wire logic iUserMode,
	input wire logic iInterruptPending,
	input wire logic iAluTrap,
	output ctrlStateT oState
);

	ctrlStateT state;
	ctrlStateT nextState;

	// state register
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= FETCH;
		else
			state <= nextState;
	end

	assign oState = state;

	always_comb
	begin
		nextState = FETCH;
		case (state)
			FETCH:
				nextState = DECODE;
			DECODE:
				case (iClass.kind)
					RTYPE, MULTDIV:
						nextState = RFMT;
					SHIFTOP:
						nextState = SHIFT;
					ILOGIC:
						nextState = IFMTL;
					IARITH:
						nextState = IFMTA;
					LOAD, STORE:
						nextState = LWSW;
					// control transfers take a pending interrupt before they start
					JROP:
						nextState = iInterruptPending ? COP0EXC : JR;
					BRANCHEQ:
						nextState = iInterruptPending ? COP0EXC : BEQ;
					BRANCHNE:
						nextState = iInterruptPending ? COP0EXC : BNE;
					JUMPOP:
						nextState = iInterruptPending ? COP0EXC : JUMP;
					JALOP:
						nextState = iInterruptPending ? COP0EXC : JAL;
					// privileged, kernel mode only
					MTC0OP:
						nextState = iUserMode ? COP0EXC : COP0MTC0;
					MFC0OP:
						nextState = iUserMode ? COP0EXC : COP0MFC0;
					ERETOP:
						nextState = iUserMode ? COP0EXC : COP0ERET;
					// syscall and illegal words
					default:
						nextState = COP0EXC;
				endcase
			// mult and div write hi/lo, nothing left to do
			RFMT:
				nextState = (iClass.kind == MULTDIV) ? FETCH : RFMT2;
			SHIFT:
				nextState = RFMT2;
			IFMTL, IFMTA:
				nextState = IFMT2;
			// write-back states, last chance to trap
			RFMT2, IFMT2:
				nextState = (iAluTrap || iInterruptPending) ? COP0EXC : FETCH;
			LWSW:
				nextState = (iClass.kind == LOAD) ? LW : SW;
			LW:
				nextState = LW2;
			// lw2, sw, jumps, branches and cop0 states all close here
			default:
				nextState = FETCH;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/ctrlWordRom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_cfg.svh"

module ctrlWordRom
	import controlPkg::*;
(
	input ctrlStateT iState,
	output ctrlWordT oCtrl
);

	always_comb
	begin
		case (iState)
			// read the word at pc, pc + 4
			FETCH:
				oCtrl = '{pcWrite: 1'b1, memRead: 1'b1, irWrite: 1'b1, aluSrcB: 3'b001,
					default: '0};
			// branch target into alu out
			DECODE:
				oCtrl = '{aluSrcB: 3'b011, default: '0};
			RFMT:
				oCtrl = '{aluOp: 2'b10, aluSrcA: 2'b01, default: '0};
			// shamt on the a side
			SHIFT:
				oCtrl = '{aluOp: 2'b10, aluSrcA: 2'b10, default: '0};
			RFMT2:
				oCtrl = '{regWrite: 1'b1, regDst: 1'b1, default: '0};
			// zero-extended immediate
			IFMTL:
				oCtrl = '{aluOp: 2'b11, aluSrcB: 3'b100, aluSrcA: 2'b01, default: '0};
			// sign-extended immediate
			IFMTA:
				oCtrl = '{aluOp: 2'b11, aluSrcB: 3'b010, aluSrcA: 2'b01, default: '0};
			IFMT2:
				oCtrl = '{regWrite: 1'b1, default: '0};
			// effective address
			LWSW:
				oCtrl = '{aluSrcB: 3'b010, aluSrcA: 2'b01, default: '0};
			LW:
				oCtrl = '{iorD: 1'b1, memRead: 1'b1, default: '0};
			LW2:
				oCtrl = '{memtoReg: 1'b1, regWrite: 1'b1, default: '0};
			SW:
				oCtrl = '{iorD: 1'b1, memWrite: 1'b1, default: '0};
			// compare by subtraction, target from alu out
			BEQ:
				oCtrl = '{pcWriteBeq: 1'b1, pcSource: 3'b001, aluOp: 2'b01, aluSrcA: 2'b01,
					default: '0};
			BNE:
				oCtrl = '{pcWriteBne: 1'b1, pcSource: 3'b001, aluOp: 2'b01, aluSrcA: 2'b01,
					default: '0};
			JUMP:
				oCtrl = '{pcWrite: 1'b1, pcSource: 3'b010, default: '0};
			// link address written through store select 1
			JAL:
				oCtrl = '{pcWrite: 1'b1, regWrite: 1'b1, pcSource: 3'b010, aluOp: 2'b11,
					aluSrcB: 3'b101, store: 3'b001, default: '0};
			JR:
				oCtrl = '{pcWrite: 1'b1, pcSource: 3'b011, default: '0};
			// cop0 register read back into rt
			COP0MFC0:
				oCtrl = '{regWrite: 1'b1, store: 3'b110, default: '0};
			// return to epc
			COP0ERET:
				oCtrl = '{pcWrite: 1'b1, pcSource: 3'b101, default: '0};
			// jump to the handler
			COP0EXC:
				oCtrl = '{pcWrite: 1'b1, pcSource: 3'b100, default: '0};
			// mtc0 is handled by the cop0 strobe alone
			default:
				oCtrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/exceptionUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_cfg.svh"

module exceptionUnit
	import controlPkg::*;
(
	input instrClassT iClass,
	input ctrlStateT iState,
	input wire logic iAluOverflow,
	input wire logic iExcLevel,
	input wire logic [7:0] iPendingInterrupt,
	output logic oInterruptPending,
	output logic oAluTrap,
	output cop0CtrlT oCop0
);

	logic [4:0] excCode;

	// interrupts and overflow are masked while a handler runs
	assign oInterruptPending = (|iPendingInterrupt) && !iExcLevel;
	assign oAluTrap = iClass.mayOverflow && iAluOverflow && !iExcLevel;

	// cause code, first match wins
	always_comb
	begin
		if (iClass.kind == SYSCALL)
			excCode = `EXC_SYS;
		else if (iClass.mayOverflow && iAluOverflow)
			excCode = `EXC_ALU;
		else if (iClass.kind inside {MTC0OP, MFC0OP, ERETOP})
			excCode = `EXC_INSTR;
		else if (oInterruptPending)
			excCode = `EXC_INT;
		else
			excCode = `EXC_INSTR;
	end

	always_comb
	begin
		// epc keeps the faulting pc only during the trap cycle
		oCop0.pcOriginalWrite = (iState != COP0EXC);
		oCop0.regWrite = (iState == COP0MTC0);
		oCop0.eret = (iState == COP0ERET);
		oCop0.excOccurred = (iState == COP0EXC);
		oCop0.branchDelay = iClass.delaySlot;
		oCop0.interrupted = (iState == COP0EXC) && (excCode == `EXC_INT);
		oCop0.excCode = excCode;
	end

endmodule

`default_nettype wire

// ==== source/multiCycleControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_cfg.svh"

module multiCycleControl
	import controlPkg::*;
(
	input wire logic iCLK,
	input wire logic iRST,
	input wire logic [5:0] iOp,
	input wire logic [5:0] iFunct,
	input wire logic [4:0] iFmt,
	input wire logic iAluOverflow,
	input wire logic iUserMode,
	input wire logic iExcLevel,
	input wire logic [7:0] iPendingInterrupt,
	output ctrlWordT oCtrl,
	output cop0CtrlT oCop0,
	output ctrlStateT oState
);

	instrClassT instrClass;
	ctrlStateT state;
	logic interruptPending;
	logic aluTrap;

	assign oState = state;

	// instruction register fields to one class
	instrDecoder i_instrDecoder (
		.iOp(iOp),
		.iFunct(iFunct),
		.iFmt(iFmt),
		.oClass(instrClass)
	);

	stateSequencer i_stateSequencer (
		.iCLK(iCLK),
		.iRST(iRST),
		.iClass(instrClass),
		.iUserMode(iUserMode),
		.iInterruptPending(interruptPending),
		.iAluTrap(aluTrap),
		.oState(state)
	);

	// moore outputs, straight from the state
	ctrlWordRom i_ctrlWordRom (
		.iState(state),
		.oCtrl(oCtrl)
	);

	exceptionUnit i_exceptionUnit (
		.iClass(instrClass),
		.iState(state),
		.iAluOverflow(iAluOverflow),
		.iExcLevel(iExcLevel),
		.iPendingInterrupt(iPendingInterrupt),
		.oInterruptPending(interruptPending),
		.oAluTrap(aluTrap),
		.oCop0(oCop0)
	);

endmodule

`default_nettype wire

// ==== tests/multiCycleControl_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module multiCycleControl_props
	import controlPkg::*;
(
	input wire logic iCLK,
	input wire logic iRST,
	input wire ctrlStateT state
);

	// every instruction is decoded right after its fetch
	property fetchThenDecode;
		@(posedge iCLK) disable iff (iRST)
		(state == FETCH) |=> (state == DECODE);
	endproperty

	// the trap cycle jumps to the handler and starts a new fetch
	property excThenFetch;
		@(posedge iCLK) disable iff (iRST)
		(state == COP0EXC) |=> (state == FETCH);
	endproperty

	property resetToFetch;
		@(posedge iCLK)
		iRST |=> (state == FETCH);
	endproperty

	assert property (fetchThenDecode)
	else
		$error("DECODE did not follow FETCH");

	assert property (excThenFetch)
	else
		$error("FETCH did not follow COP0EXC");

	assert property (resetToFetch)
	else
		$error("state is not FETCH after a reset cycle");

endmodule

// attach to the sequencer inside the DUT
bind stateSequencer multiCycleControl_props i_props (
	.iCLK(iCLK),
	.iRST(iRST),
	.state(state)
);

`default_nettype wire

// ==== tests/multiCycleControl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_cfg.svh"

module multiCycleControl_tb
	import controlPkg::*;
();

	// one stimulus line, inputs first, then the expected results
	typedef struct packed
	{
		logic [5:0] op;
		logic [5:0] funct;
		logic [4:0] fmt;
		logic userMode;
		logic aluOverflow;
		logic excLevel;
		logic [7:0] pendInt;
		logic [3:0] cycles;
		logic trap;
		logic [4:0] code;
		logic delaySlot;
		logic [1:0] regWrites;
		logic [1:0] memWrites;
		logic [1:0] cop0Writes;
		logic [1:0] erets;
	} stimLineT;

	logic iCLK;
	logic iRST;
	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] fmt;
	logic aluOverflow;
	logic userMode;
	logic excLevel;
	logic [7:0] pendingInterrupt;
	ctrlWordT ctrl;
	cop0CtrlT cop0;
	ctrlStateT state;

	stimLineT stimQ[$];
	int cycleCount;
	int cycleLimit;

	multiCycleControl i_dut (
		.iCLK(iCLK),
		.iRST(iRST),
		.iOp(op),
		.iFunct(funct),
		.iFmt(fmt),
		.iAluOverflow(aluOverflow),
		.iUserMode(userMode),
		.iExcLevel(excLevel),
		.iPendingInterrupt(pendingInterrupt),
		.oCtrl(ctrl),
		.oCop0(cop0),
		.oState(state)
	);

	// 40 ns period
	always #20 iCLK = ~iCLK;

	// watchdog, limit comes from the number of stimulus lines
	always @(posedge iCLK)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Error: timeout, the run did not finish within %0d cycles", cycleLimit);
			abortRun();
		end
	end

	task automatic abortRun();
		$display("Regression failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic loadStimulus();
		int fd;
		int count;
		string line;
		logic [31:0] fld [15];
		stimLineT entry;
		fd = $fopen("tests/control_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Error: cannot open tests/control_stimulus.txt");
			abortRun();
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// header and note lines start with a hash
				if (line.len() > 0 && line[0] != "#")
				begin
					count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
						fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
					if (count == 15)
					begin
						entry.op = fld[0][5:0];
						entry.funct = fld[1][5:0];
						entry.fmt = fld[2][4:0];
						entry.userMode = fld[3][0];
						entry.aluOverflow = fld[4][0];
						entry.excLevel = fld[5][0];
						entry.pendInt = fld[6][7:0];
						entry.cycles = fld[7][3:0];
						entry.trap = fld[8][0];
						entry.code = fld[9][4:0];
						entry.delaySlot = fld[10][0];
						entry.regWrites = fld[11][1:0];
						entry.memWrites = fld[12][1:0];
						entry.cop0Writes = fld[13][1:0];
						entry.erets = fld[14][1:0];
						stimQ.push_back(entry);
					end
					else if (count > 0)
					begin
						$display("Error: stimulus line has %0d fields instead of 15", count);
						abortRun();
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkReset();
		checkValue("oState", 32'(FETCH), 32'(state));
		checkValue("oCtrl.memWrite", 0, 32'(ctrl.memWrite));
		checkValue("oCtrl.regWrite", 0, 32'(ctrl.regWrite));
		checkValue("oCop0.regWrite", 0, 32'(cop0.regWrite));
		checkValue("oCop0.eret", 0, 32'(cop0.eret));
		checkValue("oCop0.excOccurred", 0, 32'(cop0.excOccurred));
		checkValue("oCop0.pcOriginalWrite", 1, 32'(cop0.pcOriginalWrite));
	endtask

	// fetch reads memory, loads ir and bumps pc, nothing else
	task automatic checkFetchWord();
		ctrlWordT expected;
		ctrlWordT masked;
		expected = '0;
		expected.pcWrite = 1'b1;
		expected.memRead = 1'b1;
		expected.irWrite = 1'b1;
		masked = ctrl;
		masked.aluSrcB = '0;
		checkValue("oCtrl in FETCH", 32'(expected), 32'(masked));
		checkValue("oCtrl.aluSrcB active in FETCH", 1, 32'(ctrl.aluSrcB != 3'b000));
	endtask

	// entered 1 ns after the edge that starts a fetch cycle, left at the same point
	task automatic runInstr(input stimLineT s);
		int cycles;
		int regWrites;
		int memWrites;
		int cop0Writes;
		int erets;
		int traps;
		bit done;
		checkValue("oState", 32'(FETCH), 32'(state));
		checkFetchWord();
		cycles = 1;
		regWrites = 0;
		memWrites = 0;
		cop0Writes = 0;
		erets = 0;
		traps = 0;
		done = 1'b0;
		#1;
		// reset ends together with the first instruction
		iRST = 1'b0;
		op = s.op;
		funct = s.funct;
		fmt = s.fmt;
		userMode = s.userMode;
		aluOverflow = s.aluOverflow;
		excLevel = s.excLevel;
		pendingInterrupt = s.pendInt;
		while (!done)
		begin
			@(posedge iCLK);
			#1;
			if (state == FETCH)
				done = 1'b1;
			else
			begin
				cycles = cycles + 1;
				regWrites = regWrites + int'(ctrl.regWrite);
				memWrites = memWrites + int'(ctrl.memWrite);
				cop0Writes = cop0Writes + int'(cop0.regWrite);
				erets = erets + int'(cop0.eret);
				// delay flag only matters while the word is decoded
				if (state == DECODE)
					checkValue("oCop0.branchDelay", 32'(s.delaySlot), 32'(cop0.branchDelay));
				if (cop0.excOccurred)
				begin
					traps = traps + 1;
					checkValue("oCop0.excCode", 32'(s.code), 32'(cop0.excCode));
					checkValue("oCop0.interrupted", 32'(s.code == `EXC_INT),
						32'(cop0.interrupted));
					checkValue("oCop0.pcOriginalWrite", 0, 32'(cop0.pcOriginalWrite));
				end
				else
				begin
					checkValue("oCop0.interrupted", 0, 32'(cop0.interrupted));
					checkValue("oCop0.pcOriginalWrite", 1, 32'(cop0.pcOriginalWrite));
				end
			end
		end
		checkValue("cycles back to FETCH", 32'(s.cycles), 32'(cycles));
		checkValue("trap cycles", 32'(s.trap), 32'(traps));
		checkValue("oCtrl.regWrite cycles", 32'(s.regWrites), 32'(regWrites));
		checkValue("oCtrl.memWrite cycles", 32'(s.memWrites), 32'(memWrites));
		checkValue("oCop0.regWrite cycles", 32'(s.cop0Writes), 32'(cop0Writes));
		checkValue("oCop0.eret cycles", 32'(s.erets), 32'(erets));
	endtask

	initial
	begin
		iCLK = 1'b0;
		iRST = 1'b1;
		op = '0;
		funct = '0;
		fmt = '0;
		aluOverflow = 1'b0;
		userMode = 1'b0;
		excLevel = 1'b0;
		pendingInterrupt = '0;
		cycleCount = 0;
		loadStimulus();
		cycleLimit = 16 + 8 * stimQ.size() + 64;
		// 16 reset cycles, then check just after the last edge
		repeat (16) @(posedge iCLK);
		#1;
		checkReset();
		foreach (stimQ[i])
			runInstr(stimQ[i]);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/control_stimulus.txt ====
# op funct fmt user ovf exl pend | cycles trap code bdelay regwr memwr c0wr eret
# all fields hex, text after the 15th field is a note
00 20 00 0 0 0 00 4 0 00 0 1 0 0 0 add
00 24 00 0 0 0 00 4 0 00 0 1 0 0 0 and
00 00 00 0 0 0 00 4 0 00 0 1 0 0 0 sll
00 03 00 0 0 0 00 4 0 00 0 1 0 0 0 sra
00 18 00 0 0 0 00 3 0 00 0 0 0 0 0 mult
00 1b 00 0 0 0 00 3 0 00 0 0 0 0 0 divu
00 08 00 0 0 0 00 3 0 00 1 0 0 0 0 jr
00 0c 00 0 0 0 00 3 1 08 0 0 0 0 0 syscall
0d 00 00 0 0 0 00 4 0 00 0 1 0 0 0 ori
0a 00 00 0 0 0 00 4 0 00 0 1 0 0 0 slti
0f 00 00 0 0 0 00 4 0 00 0 1 0 0 0 lui
23 00 00 0 0 0 00 5 0 00 0 1 0 0 0 lw
2b 00 00 0 0 0 00 4 0 00 0 0 1 0 0 sw
04 00 00 0 0 0 00 3 0 00 1 0 0 0 0 beq
05 00 00 0 0 0 00 3 0 00 1 0 0 0 0 bne
02 00 00 0 0 0 00 3 0 00 1 0 0 0 0 j
03 00 00 0 0 0 00 3 0 00 1 1 0 0 0 jal
00 20 00 0 1 0 00 5 1 0c 0 1 0 0 0 add overflow
00 22 00 0 1 1 00 4 0 00 0 1 0 0 0 sub overflow at exception level
00 22 00 0 1 0 00 5 1 0c 0 1 0 0 0 sub overflow
08 00 00 0 1 0 00 5 1 0c 0 1 0 0 0 addi overflow
08 00 00 0 1 1 00 4 0 00 0 1 0 0 0 addi overflow at exception level
04 00 00 0 0 0 01 3 1 00 1 0 0 0 0 beq with interrupt
00 24 00 0 0 0 80 5 1 00 0 1 0 0 0 and with interrupt
05 00 00 0 0 1 01 3 0 00 1 0 0 0 0 bne with masked interrupt
10 00 04 1 0 0 00 3 1 0a 0 0 0 0 0 mtc0 user
10 00 00 1 0 0 00 3 1 0a 0 0 0 0 0 mfc0 user
10 18 10 1 0 0 00 3 1 0a 0 0 0 0 0 eret user
10 00 04 0 0 0 00 3 0 00 0 0 0 1 0 mtc0 kernel
10 00 00 0 0 0 00 3 0 00 0 1 0 0 0 mfc0 kernel
10 18 10 0 0 0 00 3 0 00 0 0 0 0 1 eret kernel
3f 00 00 0 0 0 00 3 1 0a 0 0 0 0 0 unknown opcode
10 00 10 0 0 0 00 3 1 0a 0 0 0 0 0 eret with wrong funct

// ==== tb.f ====
+incdir+source
source/controlPkg.sv
source/instrDecoder.sv
source/stateSequencer.sv
source/ctrlWordRom.sv
source/exceptionUnit.sv
source/multiCycleControl.sv
tests/multiCycleControl_props.sv
tests/multiCycleControl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= multiCycleControl_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) source/control_cfg.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
